// ==== mcu_pkg.sv ====
`default_nettype none

package mcu_pkg;

   ////////////////////
   // Widths
   ////////////////////
   localparam int ADDR_W = 24;
   localparam int BYTE_W = 8;
   // Byte position within one chip-select frame
   localparam int CNT_W  = 16;

   ////////////////////
   // Command codes
   ////////////////////
   // Register loads, three parameter bytes each, MSB first
   localparam logic [BYTE_W-1:0] CMD_SET_ADDR      = 8'h00;
   localparam logic [BYTE_W-1:0] CMD_SET_ROM_MASK  = 8'h01;
   localparam logic [BYTE_W-1:0] CMD_SET_SAVE_MASK = 8'h02;
   localparam logic [BYTE_W-1:0] CMD_DMA_STOP      = 8'h40;

   // Opcode groups, matched on the high nibble
   localparam logic [3:0] CMD_GRP_MAPPER = 4'h3;
   localparam logic [3:0] CMD_GRP_DMA    = 4'h4;
   // Memory access groups. Bit 0 of the opcode asks for address auto-increment,
   // bit 4 tells the write group, whose data trails the command by one byte
   localparam logic [3:0] CMD_GRP_READ   = 4'h8;
   localparam logic [3:0] CMD_GRP_WRITE  = 4'h9;

   // Commands answered on MISO
   localparam logic [BYTE_W-1:0] CMD_ID     = 8'hF0;
   localparam logic [BYTE_W-1:0] CMD_STATUS = 8'hF1;
   localparam logic [BYTE_W-1:0] CMD_ECHO   = 8'hFF;
   localparam logic [BYTE_W-1:0] ID_BYTE    = 8'hA5;

   ////////////////////
   // Protocol constants
   ////////////////////
   // Byte count of the first parameter byte
   localparam int PARAM_FIRST     = 2;
   localparam int SYNC_STAGES     = 2;
   // One SD sector
   localparam int DMA_BLOCK_BYTES = 512;
   localparam int DMA_CNT_W       = $clog2(DMA_BLOCK_BYTES) + 1;

endpackage

`default_nettype wire

// ==== spi_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_slave import mcu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sck,
   input  logic              mosi,
   input  logic              cs_n,
   output logic              miso,
   input  logic [BYTE_W-1:0] resp_data,
   output logic [BYTE_W-1:0] cmd_data,
   output logic [BYTE_W-1:0] param_data,
   output logic              cmd_ready,
   output logic              param_ready,
   output logic [CNT_W-1:0]  byte_cnt,
   output logic [2:0]        bit_cnt,
   output logic              start_msg,
   output logic              end_msg
);

   logic [SYNC_STAGES-1:0] sck_sync;
   logic [SYNC_STAGES-1:0] mosi_sync;
   logic [SYNC_STAGES-1:0] cs_sync;
   logic                   sck_d;
   logic                   cs_d;
   logic                   sck_s;
   logic                   mosi_s;
   logic                   cs_s;
   logic                   sck_rise;
   logic                   sck_fall;
   logic                   cs_fall;
   logic                   cs_rise;
   logic [BYTE_W-1:0]      shift_in;
   logic [BYTE_W-1:0]      shift_out;
   logic [BYTE_W-1:0]      rx_byte;

   ////////////////////
   // Pin synchronizers
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sck_sync  <= '0;
         mosi_sync <= '0;
         cs_sync   <= '1;
         sck_d     <= 1'b0;
         cs_d      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
         mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
         cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
         sck_d     <= sck_s;
         cs_d      <= cs_s;
      end
   end

   assign sck_s    = sck_sync[SYNC_STAGES-1];
   assign mosi_s   = mosi_sync[SYNC_STAGES-1];
   assign cs_s     = cs_sync[SYNC_STAGES-1];
   assign sck_rise = sck_s & ~sck_d;
   assign sck_fall = ~sck_s & sck_d;
   assign cs_fall  = ~cs_s & cs_d;
   assign cs_rise  = cs_s & ~cs_d;

   // MSB first
   assign rx_byte = {shift_in[BYTE_W-2:0], mosi_s};

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         shift_in <= rx_byte;
      end
   end

   ////////////////////
   // Byte framing and MISO
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         cmd_data    <= '0;
         param_data  <= '0;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         start_msg   <= 1'b0;
         end_msg     <= 1'b0;
         shift_out   <= '0;
      end else begin
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         start_msg   <= cs_fall;
         end_msg     <= cs_rise;
         if (cs_fall) begin
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            shift_out <= '0;
         end else if (!cs_s) begin
            if (sck_rise) begin
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  byte_cnt <= byte_cnt + CNT_W'(1);
                  // First byte of the frame is the opcode
                  if (byte_cnt == '0) begin
                     cmd_data  <= rx_byte;
                     cmd_ready <= 1'b1;
                  end else begin
                     param_data  <= rx_byte;
                     param_ready <= 1'b1;
                  end
               end
            end
            // Reply byte enters the shifter on the first falling edge of a byte
            if (sck_fall) begin
               if (bit_cnt == 3'd0) begin
                  shift_out <= resp_data;
               end else begin
                  shift_out <= {shift_out[BYTE_W-2:0], 1'b0};
               end
            end
         end
      end
   end

   assign miso = shift_out[BYTE_W-1];

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(cmd_ready && param_ready))
      else $error("cmd_ready and param_ready high together");

endmodule

`default_nettype wire

// ==== mcu_cmd.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcu_cmd import mcu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [BYTE_W-1:0] cmd_data,
   input  logic [BYTE_W-1:0] param_data,
   input  logic              cmd_ready,
   input  logic              param_ready,
   input  logic [CNT_W-1:0]  byte_cnt,
   input  logic [2:0]        bit_cnt,
   input  logic              start_msg,
   input  logic              end_msg,
   input  logic [BYTE_W-1:0] mem_rdata,
   input  logic              dma_busy,
   input  logic              dma_nextaddr,
   output logic [ADDR_W-1:0] mcu_addr,
   output logic [ADDR_W-1:0] rom_mask,
   output logic [ADDR_W-1:0] save_mask,
   output logic [BYTE_W-1:0] mcu_wdata,
   output logic [BYTE_W-1:0] resp_data,
   output logic [3:0]        mapper,
   output logic              mcu_rd_n,
   output logic              mcu_wr_n,
   output logic              dma_en
);

   logic [3:0]        cmd_grp;
   logic              mem_cmd;
   logic              in_msg;
   logic [1:0]        zero_hist;
   logic              byte_next;
   logic [CNT_W-1:0]  inc_after;
   logic              auto_inc;
   logic              rd_win;
   logic              wr_win;
   logic [BYTE_W-1:0] rd_buf;

   // Places one parameter byte into a 24-bit register by its frame position
   function automatic logic [ADDR_W-1:0] put_byte(input logic [ADDR_W-1:0] cur,
                                                  input logic [CNT_W-1:0]  pos,
                                                  input logic [BYTE_W-1:0] data);
      logic [ADDR_W-1:0] res;
      res = cur;
      case (pos)
         CNT_W'(PARAM_FIRST):     res[ADDR_W-1 -: BYTE_W]   = data;
         CNT_W'(PARAM_FIRST + 1): res[2*BYTE_W-1 -: BYTE_W] = data;
         CNT_W'(PARAM_FIRST + 2): res[BYTE_W-1:0]          = data;
         default: ;
      endcase
      return res;
   endfunction

   assign cmd_grp = cmd_data[7:4];
   assign mem_cmd = (cmd_grp == CMD_GRP_READ) || (cmd_grp == CMD_GRP_WRITE);

   ////////////////////
   // Command decode
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mapper    <= '0;
         rom_mask  <= '1;
         save_mask <= '1;
         dma_en    <= 1'b0;
      end else if (cmd_ready) begin
         case (cmd_grp)
            CMD_GRP_MAPPER: mapper <= cmd_data[3:0];
            CMD_GRP_DMA:    dma_en <= 1'b1;
            default: ;
         endcase
      end else if (param_ready) begin
         case (cmd_data)
            CMD_SET_ROM_MASK:  rom_mask  <= put_byte(rom_mask, byte_cnt, param_data);
            CMD_SET_SAVE_MASK: save_mask <= put_byte(save_mask, byte_cnt, param_data);
            CMD_DMA_STOP:      dma_en    <= 1'b0;
            default: ;
         endcase
      end
   end

   // Write data for the group 9 commands
   always_ff @(posedge clk) begin
      if (param_ready && cmd_grp == CMD_GRP_WRITE) begin
         mcu_wdata <= param_data;
      end
   end

   ////////////////////
   // Address counter
   ////////////////////
   // One pulse per byte, the cycle after bit_cnt wraps to 0
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         zero_hist <= '0;
         in_msg    <= 1'b0;
      end else begin
         zero_hist <= {zero_hist[0], bit_cnt == 3'd0};
         if (start_msg) begin
            in_msg <= 1'b1;
         end else if (end_msg) begin
            in_msg <= 1'b0;
         end
      end
   end

   assign byte_next = (zero_hist == 2'b01);
   // Writes skip one extra byte since data lags the command
   assign inc_after = CNT_W'(1) + CNT_W'(cmd_data[4]);
   assign auto_inc  = byte_next && in_msg && mem_cmd && cmd_data[0] && (byte_cnt > inc_after);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mcu_addr <= '0;
      end else if (param_ready && cmd_data == CMD_SET_ADDR) begin
         if (byte_cnt == CNT_W'(PARAM_FIRST)) begin
            mcu_addr <= {param_data, {(ADDR_W-BYTE_W){1'b0}}};
         end else begin
            mcu_addr <= put_byte(mcu_addr, byte_cnt, param_data);
         end
      end else if (dma_nextaddr || auto_inc) begin
         mcu_addr <= mcu_addr + ADDR_W'(1);
      end
   end

   ////////////////////
   // Memory strobes
   ////////////////////
   assign wr_win = in_msg && (cmd_grp == CMD_GRP_WRITE) &&
                   (bit_cnt inside {3'd1, 3'd2, 3'd3}) &&
                   (byte_cnt >= CNT_W'(PARAM_FIRST));
   // Read is held three bits so data settles before bit 7
   assign rd_win = in_msg && (cmd_grp == CMD_GRP_READ) &&
                   (bit_cnt inside {3'd5, 3'd6, 3'd7}) &&
                   (byte_cnt != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mcu_wr_n <= 1'b1;
         mcu_rd_n <= 1'b1;
      end else begin
         mcu_wr_n <= ~wr_win;
         mcu_rd_n <= ~rd_win;
      end
   end

   always_ff @(posedge clk) begin
      if (bit_cnt == 3'd7) begin
         rd_buf <= mem_rdata;
      end
   end

   // Reply is picked once the byte is complete, so it sees the fresh opcode
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_data <= '0;
      end else if (cmd_ready || param_ready) begin
         case (cmd_data)
            CMD_ID:     resp_data <= ID_BYTE;
            CMD_STATUS: resp_data <= {dma_busy, {(BYTE_W-1){1'b0}}};
            CMD_ECHO:   resp_data <= param_data;
            default:    resp_data <= rd_buf;
         endcase
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(!mcu_rd_n && !mcu_wr_n))
      else $error("MCU read and write strobes low together");

endmodule

`default_nettype wire

// ==== sd_dma.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_dma import mcu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              dma_en,
   input  logic              sd_strobe,
   input  logic [BYTE_W-1:0] sd_data,
   output logic              dma_busy,
   output logic              dma_we,
   output logic [BYTE_W-1:0] dma_wdata,
   output logic              dma_nextaddr
);

   logic                 en_d;
   logic [DMA_CNT_W-1:0] dma_cnt;
   logic                 block_done;

   assign block_done = (dma_cnt == DMA_CNT_W'(DMA_BLOCK_BYTES));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         en_d         <= 1'b0;
         dma_busy     <= 1'b0;
         dma_we       <= 1'b0;
         dma_nextaddr <= 1'b0;
         dma_cnt      <= '0;
      end else begin
         en_d         <= dma_en;
         dma_we       <= 1'b0;
         dma_nextaddr <= dma_we;
         if (dma_en && !en_d) begin
            dma_busy <= 1'b1;
            dma_cnt  <= '0;
         end else if (dma_busy) begin
            if (sd_strobe && !block_done) begin
               dma_we  <= 1'b1;
               dma_cnt <= dma_cnt + DMA_CNT_W'(1);
            end
            // Idle right after the last write of the sector
            if (dma_we && block_done) begin
               dma_busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sd_strobe) begin
         dma_wdata <= sd_data;
      end
   end

   a_we_busy: assert property (@(posedge clk) disable iff (!rst_n)
      dma_we |-> dma_busy)
      else $error("DMA write outside a busy sector");

endmodule

`default_nettype wire

// ==== sram_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_port import mcu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [ADDR_W-1:0] mcu_addr,
   input  logic [ADDR_W-1:0] rom_mask,
   input  logic [BYTE_W-1:0] mcu_wdata,
   input  logic              mcu_rd_n,
   input  logic              mcu_wr_n,
   input  logic              dma_busy,
   input  logic              dma_we,
   input  logic [BYTE_W-1:0] dma_wdata,
   output logic [BYTE_W-1:0] mem_rdata,
   output logic [ADDR_W-1:0] sram_addr,
   output logic [BYTE_W-1:0] sram_wdata,
   output logic              sram_we_n,
   output logic              sram_oe_n,
   input  logic [BYTE_W-1:0] sram_rdata
);

   ////////////////////
   // Bus strobes
   ////////////////////
   // DMA owns the bus while busy and never reads
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sram_we_n <= 1'b1;
         sram_oe_n <= 1'b1;
      end else begin
         sram_we_n <= dma_busy ? ~dma_we : mcu_wr_n;
         sram_oe_n <= dma_busy ? 1'b1 : mcu_rd_n;
      end
   end

   // Address and data registered in step with the strobes
   always_ff @(posedge clk) begin
      sram_addr  <= mcu_addr & rom_mask;
      sram_wdata <= dma_busy ? dma_wdata : mcu_wdata;
   end

   assign mem_rdata = sram_rdata;

   a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(!sram_we_n && !sram_oe_n))
      else $error("SRAM write and output enable low together");

endmodule

`default_nettype wire

// ==== mcu_cart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcu_cart_top import mcu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sck,
   input  logic              mosi,
   input  logic              cs_n,
   output logic              miso,
   input  logic              sd_strobe,
   input  logic [BYTE_W-1:0] sd_data,
   output logic [ADDR_W-1:0] sram_addr,
   output logic [BYTE_W-1:0] sram_wdata,
   input  logic [BYTE_W-1:0] sram_rdata,
   output logic              sram_we_n,
   output logic              sram_oe_n,
   output logic [3:0]        mapper,
   output logic [ADDR_W-1:0] save_mask
);

   // SPI to command decoder
   logic [BYTE_W-1:0] cmd_data;
   logic [BYTE_W-1:0] param_data;
   logic              cmd_ready;
   logic              param_ready;
   logic [CNT_W-1:0]  byte_cnt;
   logic [2:0]        bit_cnt;
   logic              start_msg;
   logic              end_msg;
   logic [BYTE_W-1:0] resp_data;

   // Decoder to SRAM port
   logic [ADDR_W-1:0] mcu_addr;
   logic [ADDR_W-1:0] rom_mask;
   logic [BYTE_W-1:0] mcu_wdata;
   logic [BYTE_W-1:0] mem_rdata;
   logic              mcu_rd_n;
   logic              mcu_wr_n;

   // DMA engine
   logic              dma_en;
   logic              dma_busy;
   logic              dma_we;
   logic [BYTE_W-1:0] dma_wdata;
   logic              dma_nextaddr;

   spi_slave spi_slave_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .sck         (sck),
      .mosi        (mosi),
      .cs_n        (cs_n),
      .miso        (miso),
      .resp_data   (resp_data),
      .cmd_data    (cmd_data),
      .param_data  (param_data),
      .cmd_ready   (cmd_ready),
      .param_ready (param_ready),
      .byte_cnt    (byte_cnt),
      .bit_cnt     (bit_cnt),
      .start_msg   (start_msg),
      .end_msg     (end_msg)
   );

   mcu_cmd mcu_cmd_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_data     (cmd_data),
      .param_data   (param_data),
      .cmd_ready    (cmd_ready),
      .param_ready  (param_ready),
      .byte_cnt     (byte_cnt),
      .bit_cnt      (bit_cnt),
      .start_msg    (start_msg),
      .end_msg      (end_msg),
      .mem_rdata    (mem_rdata),
      .dma_busy     (dma_busy),
      .dma_nextaddr (dma_nextaddr),
      .mcu_addr     (mcu_addr),
      .rom_mask     (rom_mask),
      .save_mask    (save_mask),
      .mcu_wdata    (mcu_wdata),
      .resp_data    (resp_data),
      .mapper       (mapper),
      .mcu_rd_n     (mcu_rd_n),
      .mcu_wr_n     (mcu_wr_n),
      .dma_en       (dma_en)
   );

   sd_dma sd_dma_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .dma_en       (dma_en),
      .sd_strobe    (sd_strobe),
      .sd_data      (sd_data),
      .dma_busy     (dma_busy),
      .dma_we       (dma_we),
      .dma_wdata    (dma_wdata),
      .dma_nextaddr (dma_nextaddr)
   );

   sram_port sram_port_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .mcu_addr   (mcu_addr),
      .rom_mask   (rom_mask),
      .mcu_wdata  (mcu_wdata),
      .mcu_rd_n   (mcu_rd_n),
      .mcu_wr_n   (mcu_wr_n),
      .dma_busy   (dma_busy),
      .dma_we     (dma_we),
      .dma_wdata  (dma_wdata),
      .mem_rdata  (mem_rdata),
      .sram_addr  (sram_addr),
      .sram_wdata (sram_wdata),
      .sram_we_n  (sram_we_n),
      .sram_oe_n  (sram_oe_n),
      .sram_rdata (sram_rdata)
   );

endmodule

`default_nettype wire

// ==== tb_mcu_cart.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_cart import mcu_pkg::*; ();

   localparam longint CLK_PERIOD = 100;
   // clk cycles per SCK half period
   localparam longint HALF_CLKS  = 8;
   localparam longint SCK_PERIOD = 2 * HALF_CLKS * CLK_PERIOD;
   localparam longint SD_GAP     = 4;
   localparam longint MAX_LEN    = 8;
   localparam int     N_ENTRIES  = 19;
   localparam logic [31:0] SEED  = 32'd66123;
   localparam longint WATCHDOG_NS = 2 * (longint'(N_ENTRIES) * MAX_LEN * 8 * SCK_PERIOD +
                                         longint'(DMA_BLOCK_BYTES) * SD_GAP * CLK_PERIOD);

   // Message bytes left aligned with byte 0 in the top bits
   typedef struct packed {
      logic [3:0]        len;
      logic [0:7][7:0]   msg;
      logic [0:7][7:0]   rsp;
      logic [0:7]        chk;
      logic [2:0]        mem_n;
      logic [15:0]       mem_addr;
      logic [0:3][7:0]   mem_data;
      logic              wa_chk;
      logic [ADDR_W-1:0] wa_exp;
      logic              dma_run;
   } entry_t;

   logic              clk;
   logic              rst_n;
   logic              sck;
   logic              mosi;
   logic              cs_n;
   logic              miso;
   logic              sd_strobe;
   logic [BYTE_W-1:0] sd_data;
   logic [ADDR_W-1:0] sram_addr;
   logic [BYTE_W-1:0] sram_wdata;
   logic [BYTE_W-1:0] sram_rdata;
   logic              sram_we_n;
   logic              sram_oe_n;
   logic [3:0]        mapper;
   logic [ADDR_W-1:0] save_mask;

   logic [BYTE_W-1:0] sram_mem [0:65535];
   logic [ADDR_W-1:0] wr_addr_q;
   logic [BYTE_W-1:0] wr_data_q;
   logic              wr_pending;
   logic [ADDR_W-1:0] last_wr_addr;
   logic [BYTE_W-1:0] dma_bytes [0:DMA_BLOCK_BYTES-1];
   entry_t            tbl [0:N_ENTRIES-1];
   int                n_tbl;
   logic [3:0]        exp_mapper;
   logic [ADDR_W-1:0] exp_save_mask;
   int                n_checks;
   int                n_errors;

   mcu_cart_top mcu_cart_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .sck        (sck),
      .mosi       (mosi),
      .cs_n       (cs_n),
      .miso       (miso),
      .sd_strobe  (sd_strobe),
      .sd_data    (sd_data),
      .sram_addr  (sram_addr),
      .sram_wdata (sram_wdata),
      .sram_rdata (sram_rdata),
      .sram_we_n  (sram_we_n),
      .sram_oe_n  (sram_oe_n),
      .mapper     (mapper),
      .save_mask  (save_mask)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////
   // SRAM model
   ////////////////////
   // Read data only while the output enable is low
   assign sram_rdata = sram_oe_n ? 'x : sram_mem[sram_addr[15:0]];

   // Bus sampled mid-cycle and byte stored once the write strobe has risen
   initial begin
      wr_pending   = 1'b0;
      last_wr_addr = '0;
      for (int a = 0; a < 65536; a++) begin
         sram_mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'hC3;
      end
      forever begin
         @(negedge clk);
         if (!sram_we_n) begin
            wr_addr_q  = sram_addr;
            wr_data_q  = sram_wdata;
            wr_pending = 1'b1;
         end else if (wr_pending) begin
            sram_mem[wr_addr_q[15:0]] = wr_data_q;
            last_wr_addr              = wr_addr_q;
            wr_pending                = 1'b0;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////
   task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                             input logic [BYTE_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                             input logic [ADDR_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_mapper(input string name, input logic [3:0] exp, input logic [3:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////
   // SPI mode 0 master that takes MISO just before each rising SCK
   task automatic send_msg(input logic [3:0] len, input logic [0:7][7:0] msg,
                           output logic [0:7][7:0] rsp);
      logic [7:0] rx;
      rsp = '0;
      rx  = '0;
      @(negedge clk);
      cs_n = 1'b0;
      repeat (HALF_CLKS) @(negedge clk);
      for (int i = 0; i < int'(len); i++) begin
         for (int b = 7; b >= 0; b--) begin
            mosi = msg[i[2:0]][b[2:0]];
            repeat (HALF_CLKS) @(negedge clk);
            rx  = {rx[6:0], miso};
            sck = 1'b1;
            repeat (HALF_CLKS) @(negedge clk);
            sck = 1'b0;
         end
         rsp[i[2:0]] = rx;
      end
      repeat (HALF_CLKS) @(negedge clk);
      cs_n = 1'b1;
      mosi = 1'b0;
      repeat (2 * HALF_CLKS) @(negedge clk);
   endtask

   // One SD byte every SD_GAP cycles
   task automatic stream_sector();
      for (int k = 0; k < DMA_BLOCK_BYTES; k++) begin
         @(negedge clk);
         sd_strobe = 1'b1;
         sd_data   = dma_bytes[k[8:0]];
         @(negedge clk);
         sd_strobe = 1'b0;
         repeat (SD_GAP - 2) @(negedge clk);
      end
      // Last write, address step and busy release
      repeat (SD_GAP) @(negedge clk);
   endtask

   task automatic add_msg(input logic [3:0] len, input logic [63:0] msg, input logic [63:0] rsp,
                          input logic [7:0] chk);
      entry_t e;
      e     = '0;
      e.len = len;
      e.msg = msg;
      e.rsp = rsp;
      e.chk = chk;
      tbl[n_tbl[4:0]] = e;
      n_tbl++;
   endtask

   task automatic expect_mem(input logic [15:0] addr, input logic [2:0] n, input logic [31:0] data);
      int last;
      last = n_tbl - 1;
      tbl[last[4:0]].mem_addr = addr;
      tbl[last[4:0]].mem_n    = n;
      tbl[last[4:0]].mem_data = data;
   endtask

   task automatic expect_wr_addr(input logic [ADDR_W-1:0] addr);
      int last;
      last = n_tbl - 1;
      tbl[last[4:0]].wa_chk = 1'b1;
      tbl[last[4:0]].wa_exp = addr;
   endtask

   task automatic with_dma(input logic [15:0] addr);
      int last;
      last = n_tbl - 1;
      tbl[last[4:0]].dma_run  = 1'b1;
      tbl[last[4:0]].mem_addr = addr;
   endtask

   task automatic run_entry(input entry_t e);
      logic [0:7][7:0] got;
      logic [15:0]     addr;
      send_msg(e.len, e.msg, got);
      for (int i = 0; i < int'(e.len); i++) begin
         if (e.chk[i[2:0]]) begin
            check_byte($sformatf("miso byte %0d of cmd %h", i, e.msg[0]),
                       e.rsp[i[2:0]], got[i[2:0]]);
         end
      end
      // Mapper holds the low nibble of the last group 3 opcode
      if (e.msg[0][7:4] == CMD_GRP_MAPPER) begin
         exp_mapper = e.msg[0][3:0];
      end
      check_mapper("mapper", exp_mapper, mapper);
      // Save mask loads from three parameter bytes, MSB first
      if (e.msg[0] == CMD_SET_SAVE_MASK) begin
         exp_save_mask = {e.msg[1], e.msg[2], e.msg[3]};
      end
      check_addr("save_mask", exp_save_mask, save_mask);
      if (e.dma_run) begin
         stream_sector();
         for (int k = 0; k < DMA_BLOCK_BYTES; k++) begin
            addr = e.mem_addr + k[15:0];
            check_byte($sformatf("sram[%h]", addr), dma_bytes[k[8:0]], sram_mem[addr]);
         end
      end
      for (int j = 0; j < int'(e.mem_n); j++) begin
         addr = e.mem_addr + j[15:0];
         check_byte($sformatf("sram[%h]", addr), e.mem_data[j[1:0]], sram_mem[addr]);
      end
      if (e.wa_chk) begin
         check_addr("sram_addr of last write", e.wa_exp, last_wr_addr);
      end
   endtask

   task automatic build_table();
      n_tbl = 0;
      add_msg(4'd2, 64'hF000_0000_0000_0000, 64'h00A5_0000_0000_0000, 8'h40);
      add_msg(4'd3, 64'hFF3C_0000_0000_0000, 64'h0000_3C00_0000_0000, 8'h20);
      // Incrementing write from 000100
      add_msg(4'd4, 64'h0000_0100_0000_0000, 64'h0, 8'h00);
      add_msg(4'd6, 64'h9111_2233_4400_0000, 64'h0, 8'h00);
      expect_mem(16'h0100, 3'd4, 32'h1122_3344);
      // Fixed address write where the last byte wins
      add_msg(4'd4, 64'h0000_0200_0000_0000, 64'h0, 8'h00);
      add_msg(4'd6, 64'h9055_6677_8800_0000, 64'h0, 8'h00);
      expect_mem(16'h0200, 3'd1, 32'h8800_0000);
      expect_wr_addr(24'h000200);
      // Read back with increment
      add_msg(4'd4, 64'h0000_0100_0000_0000, 64'h0, 8'h00);
      add_msg(4'd5, 64'h8100_0000_0000_0000, 64'h0000_1122_3300_0000, 8'h38);
      // ROM mask
      add_msg(4'd4, 64'h0100_FFFF_0000_0000, 64'h0, 8'h00);
      add_msg(4'd4, 64'h0012_3456_0000_0000, 64'h0, 8'h00);
      add_msg(4'd3, 64'h919A_0000_0000_0000, 64'h0, 8'h00);
      expect_mem(16'h3456, 3'd1, 32'h9A00_0000);
      expect_wr_addr(24'h003456);
      // Save mask
      add_msg(4'd4, 64'h0200_7FFF_0000_0000, 64'h0, 8'h00);
      add_msg(4'd1, 64'h3700_0000_0000_0000, 64'h0, 8'h00);
      add_msg(4'd2, 64'hF100_0000_0000_0000, 64'h0, 8'h40);
      // Sector DMA to 000800
      add_msg(4'd4, 64'h0000_0800_0000_0000, 64'h0, 8'h00);
      add_msg(4'd1, 64'h4000_0000_0000_0000, 64'h0, 8'h00);
      add_msg(4'd2, 64'hF100_0000_0000_0000, 64'h0080_0000_0000_0000, 8'h40);
      with_dma(16'h0800);
      add_msg(4'd2, 64'hF100_0000_0000_0000, 64'h0, 8'h40);
      add_msg(4'd2, 64'h4000_0000_0000_0000, 64'h0, 8'h00);
   endtask

   initial begin
      logic [31:0] state;
      rst_n         = 1'b0;
      sck           = 1'b0;
      mosi          = 1'b0;
      cs_n          = 1'b1;
      sd_strobe     = 1'b0;
      sd_data       = '0;
      exp_mapper    = '0;
      exp_save_mask = '1;
      n_checks      = 0;
      n_errors      = 0;
      state         = SEED;
      for (int k = 0; k < DMA_BLOCK_BYTES; k++) begin
         state              = next_rand(state);
         dma_bytes[k[8:0]] = state[7:0];
      end
      build_table();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      repeat (4) @(negedge clk);
      for (int k = 0; k < n_tbl; k++) begin
         run_entry(tbl[k[4:0]]);
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
mcu_pkg.sv
spi_slave.sv
mcu_cmd.sv
sd_dma.sv
sram_port.sv
mcu_cart_top.sv
tb_mcu_cart.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module tb_mcu_cart \
   -f filelist.f -o tb_mcu_cart
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_mcu_cart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
exit 0
